//--- rtl/rv32i_types.sv
package rv32i_types;

    // machine and ROB sizes
    localparam int ROB_DEPTH    = 32;
    localparam int ROB_IDX_W    = 5;   // log2 of ROB_DEPTH
    localparam int XLEN         = 32;
    localparam int CDB_CHANNELS = 3;   // alu, mem, br

    // state of one ROB slot
    typedef enum logic [1:0] {
        rob_empty = 2'b00,
        rob_wait  = 2'b01,  // dispatched, result not back yet
        rob_done  = 2'b10   // result on the CDB, ready to retire
    } rob_status_t;

    // instruction class as seen by the back end
    typedef enum logic [1:0] {
        op_alu = 2'b00,
        op_mem = 2'b01,
        op_br  = 2'b10
    } op_type_t;

    // one instruction handed over by dispatch
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        op_type_t        op_type;
        logic [4:0]      rd_addr;
        logic [4:0]      rs1_addr;
        logic [4:0]      rs2_addr;
        logic            regf_we;   // instruction writes rd
    } dispatch_t;

    // one result channel of the common data bus
    typedef struct packed {
        logic                 valid;
        logic [ROB_IDX_W-1:0] rob_idx;
        logic [XLEN-1:0]      data;
    } cdb_chan_t;

    // branch channel carries the resolved outcome as well
    typedef struct packed {
        cdb_chan_t       chan;
        logic            br_en;       // branch taken
        logic [XLEN-1:0] pc_new;      // resolved target
        logic            prediction;  // predicted taken
    } cdb_br_t;

    typedef struct packed {
        cdb_chan_t alu;
        cdb_chan_t mem;
        cdb_br_t   br;
    } cdb_t;

    // one reorder buffer slot
    typedef struct packed {
        logic            valid;
        rob_status_t     status;
        logic [XLEN-1:0] pc;
        op_type_t        op_type;
        logic [4:0]      rd_addr;
        logic            regf_we;
        logic [XLEN-1:0] rd_data;
        logic            br_en;
        logic [XLEN-1:0] pc_new;
        logic            prediction;
    } rob_entry_t;

    // retire event, fans out to regfile, rename table and the outside
    typedef struct packed {
        logic                 valid;
        logic [XLEN-1:0]      pc;
        logic [ROB_IDX_W-1:0] rob_idx;
        logic [4:0]           rd_addr;
        logic                 regf_we;
        logic [XLEN-1:0]      rd_data;
    } commit_t;

endpackage

//--- rtl/rob.sv
`timescale 1ns/1ps

module rob
    import rv32i_types::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  dispatch_t            dispatch_i,
    input  cdb_t                 cdb_i,
    input  logic                 retire_i,
    input  logic                 flush_i,
    output logic [ROB_IDX_W-1:0] tail_idx_o,
    output logic [ROB_IDX_W-1:0] head_idx_o,
    output rob_entry_t           head_entry_o,
    output logic                 full_o
);

    rob_entry_t table_q [ROB_DEPTH];
    rob_entry_t table_d [ROB_DEPTH];

    logic [ROB_IDX_W-1:0] head_q;
    logic [ROB_IDX_W-1:0] tail_q;
    logic [ROB_IDX_W:0]   count_q;   // one extra bit so a full ROB is distinct from empty

    rob_entry_t new_entry;
    cdb_chan_t  chans [CDB_CHANNELS];
    logic       insert;

    // a channel writes back only into a live slot still waiting for its result
    function automatic logic wb_hit(cdb_chan_t ch, rob_entry_t e);
        return ch.valid && e.valid && (e.status == rob_wait);
    endfunction

    // full does not look at retire, so ready has no path from the commit logic
    assign full_o = (count_q == (ROB_IDX_W+1)'(ROB_DEPTH));
    assign insert = dispatch_i.valid && !full_o;

    assign tail_idx_o   = tail_q;
    assign head_idx_o   = head_q;
    assign head_entry_o = table_q[head_q];

    assign chans[0] = cdb_i.alu;
    assign chans[1] = cdb_i.mem;
    assign chans[2] = cdb_i.br.chan;

    // slot contents for a new dispatch
    always_comb begin
        new_entry         = '0;
        new_entry.valid   = 1'b1;
        new_entry.status  = rob_wait;
        new_entry.pc      = dispatch_i.pc;
        new_entry.op_type = dispatch_i.op_type;
        new_entry.rd_addr = dispatch_i.rd_addr;
        new_entry.regf_we = dispatch_i.regf_we;
    end

    always_comb begin
        table_d = table_q;

        // writeback from all three channels, matched on ROB index only
        for (int c = 0; c < CDB_CHANNELS; c++) begin
            if (wb_hit(chans[c], table_q[chans[c].rob_idx])) begin
                table_d[chans[c].rob_idx].status  = rob_done;
                table_d[chans[c].rob_idx].rd_data = chans[c].data;
            end
        end

        // branch outcome travels with the branch result
        if (wb_hit(cdb_i.br.chan, table_q[cdb_i.br.chan.rob_idx])) begin
            table_d[cdb_i.br.chan.rob_idx].br_en      = cdb_i.br.br_en;
            table_d[cdb_i.br.chan.rob_idx].pc_new     = cdb_i.br.pc_new;
            table_d[cdb_i.br.chan.rob_idx].prediction = cdb_i.br.prediction;
        end

        if (retire_i) begin
            table_d[head_q] = '0;   // slot is free again
        end

        if (insert) begin
            table_d[tail_q] = new_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            table_q <= '{default: '0};
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            // drop everything younger than the retiring branch
            table_q <= '{default: '0};
            head_q  <= head_q + ROB_IDX_W'(1);
            tail_q  <= head_q + ROB_IDX_W'(1);
            count_q <= '0;
        end else begin
            table_q <= table_d;
            if (retire_i) begin
                head_q <= head_q + ROB_IDX_W'(1);
            end
            if (insert) begin
                tail_q <= tail_q + ROB_IDX_W'(1);
            end
            case ({insert, retire_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;   // none, or one in and one out
            endcase
        end
    end

endmodule

//--- rtl/rename_table.sv
`timescale 1ns/1ps

module rename_table
    import rv32i_types::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  dispatch_t            dispatch_i,
    input  logic                 dispatch_fire_i,
    input  logic [ROB_IDX_W-1:0] alloc_idx_i,
    input  commit_t              commit_i,
    input  logic                 flush_i,
    output logic [ROB_IDX_W-1:0] rs1_tag_o,
    output logic                 rs1_busy_o,
    output logic [ROB_IDX_W-1:0] rs2_tag_o,
    output logic                 rs2_busy_o
);

    logic [31:0]          busy_q;            // one flag per architectural register
    logic [ROB_IDX_W-1:0] tag_q [32];        // producing ROB slot

    logic alloc_rd;
    logic release_rd;

    // lookup sees the table before this cycle's dispatch lands
    assign rs1_tag_o  = tag_q[dispatch_i.rs1_addr];
    assign rs1_busy_o = busy_q[dispatch_i.rs1_addr];
    assign rs2_tag_o  = tag_q[dispatch_i.rs2_addr];
    assign rs2_busy_o = busy_q[dispatch_i.rs2_addr];

    assign alloc_rd = dispatch_fire_i && dispatch_i.regf_we && (dispatch_i.rd_addr != 5'd0);

    // only the latest producer may release the register
    assign release_rd = commit_i.valid && commit_i.regf_we
                        && busy_q[commit_i.rd_addr]
                        && (tag_q[commit_i.rd_addr] == commit_i.rob_idx);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= '0;
            tag_q  <= '{default: '0};
        end else if (flush_i) begin
            busy_q <= '0;   // nothing younger than the branch survives
        end else begin
            if (release_rd) begin
                busy_q[commit_i.rd_addr] <= 1'b0;
            end
            // a new producer of the same rd overrides the release above
            if (alloc_rd) begin
                busy_q[dispatch_i.rd_addr] <= 1'b1;
                tag_q[dispatch_i.rd_addr]  <= alloc_idx_i;
            end
        end
    end

endmodule

//--- rtl/commit_unit.sv
`timescale 1ns/1ps

module commit_unit
    import rv32i_types::*;
(
    input  rob_entry_t           head_entry_i,
    input  logic [ROB_IDX_W-1:0] head_idx_i,
    output logic                 retire_o,
    output logic                 flush_o,
    output commit_t              commit_o,
    output logic                 redirect_valid_o,
    output logic [XLEN-1:0]      redirect_pc_o
);

    logic is_branch;
    logic mispredict;

    assign retire_o  = head_entry_i.valid && (head_entry_i.status == rob_done);
    assign is_branch = (head_entry_i.op_type == op_br);

    // only the direction bit is predicted, so a wrong direction is the only miss
    assign mispredict = is_branch && (head_entry_i.br_en != head_entry_i.prediction);

    assign flush_o          = retire_o && mispredict;
    assign redirect_valid_o = flush_o;

    // taken goes to the resolved target, not taken falls through
    always_comb begin
        if (head_entry_i.br_en) begin
            redirect_pc_o = head_entry_i.pc_new;
        end else begin
            redirect_pc_o = head_entry_i.pc + XLEN'(4);
        end
    end

    always_comb begin
        commit_o         = '0;
        commit_o.valid   = retire_o;
        commit_o.pc      = head_entry_i.pc;
        commit_o.rob_idx = head_idx_i;
        commit_o.rd_addr = head_entry_i.rd_addr;
        commit_o.regf_we = head_entry_i.regf_we;   // branches keep their rd write on flush
        commit_o.rd_data = head_entry_i.rd_data;
    end

endmodule

//--- rtl/arch_regfile.sv
`timescale 1ns/1ps

module arch_regfile
    import rv32i_types::*;
(
    input  logic            clk,
    input  logic            rst,
    input  commit_t         commit_i,
    input  logic [4:0]      rs1_addr_i,
    input  logic [4:0]      rs2_addr_i,
    output logic [XLEN-1:0] rs1_data_o,
    output logic [XLEN-1:0] rs2_data_o
);

    logic [XLEN-1:0] regs_q [32];
    logic            we;

    assign we = commit_i.valid && commit_i.regf_we && (commit_i.rd_addr != 5'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            regs_q <= '{default: '0};
        end else if (we) begin
            regs_q[commit_i.rd_addr] <= commit_i.rd_data;
        end
    end

    // committed values only, no bypass of the commit in flight
    assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs_q[rs2_addr_i];

endmodule

//--- rtl/rob_backend.sv
`timescale 1ns/1ps

module rob_backend
    import rv32i_types::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  dispatch_t            dispatch_i,
    output logic                 dispatch_ready_o,
    output logic [ROB_IDX_W-1:0] dispatch_rob_idx_o,
    output logic [ROB_IDX_W-1:0] rs1_tag_o,
    output logic                 rs1_busy_o,
    output logic [ROB_IDX_W-1:0] rs2_tag_o,
    output logic                 rs2_busy_o,
    output logic [XLEN-1:0]      rs1_data_o,
    output logic [XLEN-1:0]      rs2_data_o,
    input  cdb_t                 cdb_i,
    output commit_t              commit_o,
    output logic                 redirect_valid_o,
    output logic [XLEN-1:0]      redirect_pc_o
);

    logic [ROB_IDX_W-1:0] tail_idx;
    logic [ROB_IDX_W-1:0] head_idx;
    rob_entry_t           head_entry;
    logic                 rob_full;
    logic                 retire;
    logic                 flush;
    logic                 dispatch_fire;

    assign dispatch_ready_o   = !rob_full;
    assign dispatch_fire      = dispatch_i.valid && dispatch_ready_o;
    assign dispatch_rob_idx_o = tail_idx;   // index the next dispatch will get

    rob u_rob (
        .clk          (clk),
        .rst          (rst),
        .dispatch_i   (dispatch_i),
        .cdb_i        (cdb_i),
        .retire_i     (retire),
        .flush_i      (flush),
        .tail_idx_o   (tail_idx),
        .head_idx_o   (head_idx),
        .head_entry_o (head_entry),
        .full_o       (rob_full)
    );

    rename_table u_rename (
        .clk             (clk),
        .rst             (rst),
        .dispatch_i      (dispatch_i),
        .dispatch_fire_i (dispatch_fire),
        .alloc_idx_i     (tail_idx),
        .commit_i        (commit_o),
        .flush_i         (flush),
        .rs1_tag_o       (rs1_tag_o),
        .rs1_busy_o      (rs1_busy_o),
        .rs2_tag_o       (rs2_tag_o),
        .rs2_busy_o      (rs2_busy_o)
    );

    commit_unit u_commit (
        .head_entry_i     (head_entry),
        .head_idx_i       (head_idx),
        .retire_o         (retire),
        .flush_o          (flush),
        .commit_o         (commit_o),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o)
    );

    arch_regfile u_regfile (
        .clk        (clk),
        .rst        (rst),
        .commit_i   (commit_o),
        .rs1_addr_i (dispatch_i.rs1_addr),
        .rs2_addr_i (dispatch_i.rs2_addr),
        .rs1_data_o (rs1_data_o),
        .rs2_data_o (rs2_data_o)
    );

endmodule

//--- test/rob_backend_tb.sv
`timescale 1ns/1ps

module rob_backend_tb
    import rv32i_types::*;
();

    typedef enum logic [1:0] {st_disp, st_cdb, st_idle} step_kind_t;

    // one row of the stimulus table
    typedef struct packed {
        step_kind_t           kind;
        op_type_t             op;
        logic [4:0]           rd;
        logic [4:0]           rs1;         // lookup address on every kind of row
        logic [4:0]           rs2;
        logic [XLEN-1:0]      pc;
        logic [1:0]           chan;        // 0 alu, 1 mem, 2 br
        logic [ROB_IDX_W-1:0] idx;         // expected dispatch index or cdb target
        logic [XLEN-1:0]      data;
        logic                 br_en;
        logic                 pred;
        logic [XLEN-1:0]      pc_new;
        logic                 exp_commit;
    } step_t;

    // in-flight instruction as the reference model sees it
    typedef struct packed {
        logic [ROB_IDX_W-1:0] idx;
        logic [XLEN-1:0]      pc;
        logic [4:0]           rd;
        logic                 we;
        logic                 is_br;
        logic                 done;
        logic [XLEN-1:0]      data;
        logic                 br_en;
        logic                 pred;
        logic [XLEN-1:0]      pc_new;
    } model_t;

    logic                 clk;
    logic                 rst;
    dispatch_t            dispatch;
    logic                 dispatch_ready;
    logic [ROB_IDX_W-1:0] dispatch_rob_idx;
    logic [ROB_IDX_W-1:0] rs1_tag;
    logic                 rs1_busy;
    logic [ROB_IDX_W-1:0] rs2_tag;
    logic                 rs2_busy;
    logic [XLEN-1:0]      rs1_data;
    logic [XLEN-1:0]      rs2_data;
    cdb_t                 cdb;
    commit_t              commit;
    logic                 redirect_valid;
    logic [XLEN-1:0]      redirect_pc;

    step_t           steps [$];
    string           names [$];
    model_t          mq [$];        // program order of everything in flight
    logic [XLEN-1:0] mregs [32];
    logic            mbusy [32];
    logic [4:0]      mtag [32];
    int              errors = 0;
    int              checks = 0;
    int              cycles = 0;
    int              limit = 0;

    rob_backend DUT (
        .clk                (clk),
        .rst                (rst),
        .dispatch_i         (dispatch),
        .dispatch_ready_o   (dispatch_ready),
        .dispatch_rob_idx_o (dispatch_rob_idx),
        .rs1_tag_o          (rs1_tag),
        .rs1_busy_o         (rs1_busy),
        .rs2_tag_o          (rs2_tag),
        .rs2_busy_o         (rs2_busy),
        .rs1_data_o         (rs1_data),
        .rs2_data_o         (rs2_data),
        .cdb_i              (cdb),
        .commit_o           (commit),
        .redirect_valid_o   (redirect_valid),
        .redirect_pc_o      (redirect_pc)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Error: run stopped after %0d cycles before the table was done", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic check_val(string name, string what, logic [31:0] exp, logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("Fail %s %s: expected %0h actual %0h", name, what, exp, act);
        end
    endtask

    task automatic add_step(string name, step_kind_t kind, op_type_t op, int rd, int rs1,
                            int rs2, int pc, int chan, int idx, bit exp_commit,
                            bit br_en = 1'b0, bit pred = 1'b0, int pc_new = 0);
        step_t s;
        s            = '0;
        s.kind       = kind;
        s.op         = op;
        s.rd         = 5'(rd);
        s.rs1        = 5'(rs1);
        s.rs2        = 5'(rs2);
        s.pc         = XLEN'(pc);
        s.chan       = 2'(chan);
        s.idx        = ROB_IDX_W'(idx);
        s.data       = (kind == st_cdb) ? $urandom : '0;
        s.br_en      = br_en;
        s.pred       = pred;
        s.pc_new     = XLEN'(pc_new);
        s.exp_commit = exp_commit;
        steps.push_back(s);
        names.push_back(name);
    endtask

    task automatic drive_step(step_t s);
        dispatch          = '0;
        cdb               = '0;
        dispatch.rs1_addr = s.rs1;
        dispatch.rs2_addr = s.rs2;
        if (s.kind == st_disp) begin
            dispatch.valid   = 1'b1;
            dispatch.pc      = s.pc;
            dispatch.op_type = s.op;
            dispatch.rd_addr = s.rd;
            dispatch.regf_we = (s.op != op_br);   // branches here have no rd
        end else if (s.kind == st_cdb) begin
            case (s.chan)
                2'd0: cdb.alu = '{valid: 1'b1, rob_idx: s.idx, data: s.data};
                2'd1: cdb.mem = '{valid: 1'b1, rob_idx: s.idx, data: s.data};
                default: begin
                    cdb.br.chan       = '{valid: 1'b1, rob_idx: s.idx, data: s.data};
                    cdb.br.br_en      = s.br_en;
                    cdb.br.pc_new     = s.pc_new;
                    cdb.br.prediction = s.pred;
                end
            endcase
        end
    endtask

    // compare the DUT with the model state and advance the model by one edge
    task automatic check_and_update(string name, step_t s);
        model_t oldest;
        model_t ent;
        logic   fire;
        logic   mispred;
        fire    = (s.kind == st_disp) && (mq.size() < ROB_DEPTH);
        mispred = 1'b0;
        check_val(name, "dispatch ready", mq.size() < ROB_DEPTH, dispatch_ready);
        check_val(name, "rs1 data", mregs[s.rs1], rs1_data);
        check_val(name, "rs2 data", mregs[s.rs2], rs2_data);
        check_val(name, "rs1 busy", mbusy[s.rs1], rs1_busy);
        check_val(name, "rs2 busy", mbusy[s.rs2], rs2_busy);
        if (mbusy[s.rs1])
            check_val(name, "rs1 tag", mtag[s.rs1], rs1_tag);
        if (mbusy[s.rs2])
            check_val(name, "rs2 tag", mtag[s.rs2], rs2_tag);
        if (s.kind == st_disp)
            check_val(name, "dispatch index", s.idx, dispatch_rob_idx);
        check_val(name, "commit valid", s.exp_commit, commit.valid);
        if (commit.valid) begin
            assert (mq.size() > 0 && mq[0].done) else begin
                errors++;
                $display("Error: %s commits an instruction whose result never came", name);
            end
            if (mq.size() > 0) begin
                oldest = mq.pop_front();
                check_val(name, "commit index", oldest.idx, commit.rob_idx);
                check_val(name, "commit pc", oldest.pc, commit.pc);
                check_val(name, "commit rd", oldest.rd, commit.rd_addr);
                check_val(name, "commit we", oldest.we, commit.regf_we);
                check_val(name, "commit data", oldest.data, commit.rd_data);
                mispred = oldest.is_br && (oldest.br_en != oldest.pred);
                if (mispred)
                    check_val(name, "redirect pc",
                              oldest.br_en ? oldest.pc_new : oldest.pc + 32'd4, redirect_pc);
                if (oldest.we && oldest.rd != 5'd0)
                    mregs[oldest.rd] = oldest.data;
                if (oldest.we && mbusy[oldest.rd] && mtag[oldest.rd] == oldest.idx)
                    mbusy[oldest.rd] = 1'b0;   // only the latest producer frees rd
            end
        end
        check_val(name, "redirect valid", mispred, redirect_valid);
        if (mispred) begin
            mq.delete();                      // younger work and this cycle's dispatch are gone
            for (int r = 0; r < 32; r++)
                mbusy[r] = 1'b0;
        end else if (fire) begin
            ent       = '0;
            ent.idx   = s.idx;
            ent.pc    = s.pc;
            ent.rd    = s.rd;
            ent.we    = (s.op != op_br);
            ent.is_br = (s.op == op_br);
            mq.push_back(ent);
            if (ent.we && s.rd != 5'd0) begin
                mbusy[s.rd] = 1'b1;
                mtag[s.rd]  = s.idx;
            end
        end
        if (s.kind == st_cdb) begin
            foreach (mq[k]) begin
                if (mq[k].idx == s.idx && !mq[k].done) begin
                    mq[k].done = 1'b1;
                    mq[k].data = s.data;
                    if (s.chan == 2'd2) begin
                        mq[k].br_en  = s.br_en;
                        mq[k].pred   = s.pred;
                        mq[k].pc_new = s.pc_new;
                    end
                end
            end
        end
    endtask

    initial begin
        void'($urandom(32'h6049d689));
        clk      = 1'b0;
        rst      = 1'b1;
        dispatch = '0;
        cdb      = '0;
        for (int r = 0; r < 32; r++) begin
            mregs[r] = '0;
            mbusy[r] = 1'b0;
            mtag[r]  = '0;
        end

        // results come back newest first but retire oldest first
        for (int i = 0; i < 5; i++)
            add_step("inorder_disp", st_disp, op_alu, i + 1, i, 0, 'h100 + 4 * i, 0, i, 0);
        for (int i = 4; i >= 0; i--)
            add_step("inorder_cdb", st_cdb, op_alu, 0, 0, 0, 0, i % 2, i, 0);
        for (int i = 1; i <= 5; i++)
            add_step("inorder_commit", st_idle, op_alu, 0, i, 0, 0, 0, 0, 1);
        add_step("x0_disp", st_disp, op_alu, 0, 1, 2, 'h200, 0, 5, 0);
        add_step("x0_cdb", st_cdb, op_alu, 0, 3, 4, 0, 0, 5, 0);
        add_step("x0_commit", st_idle, op_alu, 0, 3, 4, 0, 0, 0, 1);
        add_step("x0_read", st_idle, op_alu, 0, 0, 5, 0, 0, 0, 0);

        // fill all 32 slots so the indices wrap past 31
        for (int i = 0; i < ROB_DEPTH; i++)
            add_step("fill_disp", st_disp, op_alu, 8 + i % 8, 0, 0, 'h300 + 4 * i, 0,
                     (6 + i) % ROB_DEPTH, 0);
        add_step("full_idle", st_idle, op_alu, 0, 8, 9, 0, 0, 0, 0);
        add_step("full_disp", st_disp, op_alu, 12, 0, 0, 'h380, 0, 6, 0);
        add_step("full_cdb", st_cdb, op_alu, 0, 8, 0, 0, 0, 6, 0);
        add_step("full_commit", st_idle, op_alu, 0, 0, 0, 0, 0, 0, 1);
        add_step("ready_again", st_idle, op_alu, 0, 0, 0, 0, 0, 0, 0);
        for (int i = 1; i < ROB_DEPTH; i++)
            add_step("drain_cdb", st_cdb, op_alu, 0, 8, 15, 0, i % 2, (6 + i) % ROB_DEPTH,
                     i > 1);
        add_step("drain_last", st_idle, op_alu, 0, 0, 0, 0, 0, 0, 1);
        add_step("drained", st_idle, op_alu, 0, 8, 13, 0, 0, 0, 0);

        // two producers of x5
        add_step("rename_old", st_disp, op_alu, 5, 0, 0, 'h400, 0, 6, 0);
        add_step("rename_young", st_disp, op_alu, 5, 5, 0, 'h404, 0, 7, 0);
        add_step("rename_lookup", st_idle, op_alu, 0, 5, 5, 0, 0, 0, 0);
        add_step("rename_cdb_old", st_cdb, op_alu, 0, 5, 0, 0, 0, 6, 0);
        add_step("rename_commit_old", st_idle, op_alu, 0, 5, 0, 0, 0, 0, 1);
        add_step("rename_still_busy", st_idle, op_alu, 0, 5, 0, 0, 0, 0, 0);
        add_step("rename_cdb_young", st_cdb, op_alu, 0, 5, 0, 0, 1, 7, 0);
        add_step("rename_commit_young", st_idle, op_alu, 0, 5, 0, 0, 0, 0, 1);
        add_step("rename_clear", st_idle, op_alu, 0, 5, 5, 0, 0, 0, 0);

        // taken branch predicted not taken with three younger entries behind it
        add_step("br_disp", st_disp, op_br, 0, 1, 2, 'h500, 0, 8, 0);
        add_step("young_disp", st_disp, op_alu, 6, 0, 0, 'h504, 0, 9, 0);
        add_step("young_disp", st_disp, op_mem, 7, 0, 0, 'h508, 0, 10, 0);
        add_step("young_disp", st_disp, op_alu, 6, 0, 0, 'h50c, 0, 11, 0);
        add_step("young_cdb", st_cdb, op_alu, 0, 6, 7, 0, 0, 9, 0);
        add_step("br_cdb", st_cdb, op_alu, 0, 6, 7, 0, 2, 8, 0, 1'b1, 1'b0, 'h800);
        add_step("br_commit", st_idle, op_alu, 0, 6, 7, 0, 0, 0, 1);
        add_step("after_flush", st_idle, op_alu, 0, 6, 7, 0, 0, 0, 0);
        add_step("stale_cdb", st_cdb, op_alu, 0, 0, 0, 0, 1, 10, 0);
        add_step("stale_idle", st_idle, op_alu, 0, 0, 0, 0, 0, 0, 0);
        add_step("redirect_disp", st_disp, op_alu, 9, 0, 0, 'h800, 0, 9, 0);
        add_step("redirect_cdb", st_cdb, op_alu, 0, 9, 0, 0, 0, 9, 0);
        add_step("redirect_commit", st_idle, op_alu, 0, 9, 0, 0, 0, 0, 1);
        add_step("redirect_read", st_idle, op_alu, 0, 9, 6, 0, 0, 0, 0);

        limit = 4 * steps.size() + 100;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < steps.size(); i++) begin
            @(negedge clk);
            drive_step(steps[i]);
            #1;
            check_and_update(names[i], steps[i]);
        end

        $display("checks run %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
rtl/rv32i_types.sv
rtl/rob.sv
rtl/rename_table.sv
rtl/commit_unit.sv
rtl/arch_regfile.sv
rtl/rob_backend.sv
test/rob_backend_tb.sv
